// File: src/rope_sim_pkg.sv
/* Q16.16 fixed-point coordinate type and rope constants.
   All arithmetic on coord_t wraps and nothing saturates. */
`default_nettype none

package rope_sim_pkg;

    // fraction bits of every coordinate
    localparam int FRAC_BITS = 16;

    // signed Q16.16, screen convention so y grows downward
    typedef logic signed [31:0] coord_t;

    // masses in the rope, node 0 is the one pinned to the anchor
    localparam int NUM_NODES = 4;

    // node index, wide enough to address every node
    typedef logic [$clog2(NUM_NODES)-1:0] node_sel_t;

    // 0.3 per step, rounded to the nearest lsb (0x4ccd)
    localparam coord_t GRAVITY = coord_t'((3 * (1 << FRAC_BITS) + 5) / 10);

    // max per-axis offset between neighbours, 10.0
    localparam coord_t REST_LEN = coord_t'(10 << FRAC_BITS);

    // reset x of every node, 200.0
    localparam coord_t BASE_X = coord_t'(200 << FRAC_BITS);

    // reset y step per node index, 10.0
    localparam coord_t NODE_SPACING = coord_t'(10 << FRAC_BITS);

    // one-hot phase bits of the step sequencer, in firing order
    localparam int PH_VERLET  = 0;
    localparam int PH_FIX     = 1;
    localparam int PH_DONE    = 2;
    localparam int NUM_PHASES = 3;

endpackage

`default_nettype wire

// File: src/step_sequencer.sv
/* Fixed three-cycle step: verlet, constraint, done. No queueing,
   a step pulse that arrives while busy is dropped. */
`timescale 1ns/10ps
`default_nettype none

module step_sequencer (
    input  wire logic clk,
    input  wire logic reset,
    input  wire logic step,
    output logic      verlet_state,
    output logic      fix_constraint_state,
    output logic      step_done,
    output logic      busy
);

    import rope_sim_pkg::*;

    // one-hot phase, all zero when idle
    logic [NUM_PHASES-1:0] phase;

    // step is taken only from idle
    logic accept;

    assign accept = step && !busy;

    always_ff @(posedge clk) begin
        if (reset) begin
            phase <= '0;
        end else begin
            // hot bit enters at the verlet phase and walks toward done,
            // then falls off the top and the sequencer is idle again
            phase <= {phase[NUM_PHASES-2:0], accept};
        end
    end

    // cycle 1 after the accepting edge
    assign verlet_state = phase[PH_VERLET];

    // cycle 2, nodes load the solver output
    assign fix_constraint_state = phase[PH_FIX];

    // cycle 3, positions are final
    assign step_done = phase[PH_DONE];

    // high through all three phases
    assign busy = |phase;

endmodule

`default_nettype wire

// File: src/verlet_node.sv
/* One point mass of the rope, position-based Verlet in Q16.16.
   node_id must be below NUM_NODES and only sets the reset position. */
`timescale 1ns/10ps
`default_nettype none

module verlet_node #(
    parameter int node_id = 0
) (
    input  wire logic                 clk,
    input  wire logic                 reset,
    input  wire logic                 verlet_state,
    input  wire logic                 fix_constraint_state,
    input  wire rope_sim_pkg::coord_t x_fix_constraint,
    input  wire rope_sim_pkg::coord_t y_fix_constraint,
    output rope_sim_pkg::coord_t      x_pos,
    output rope_sim_pkg::coord_t      y_pos
);

    import rope_sim_pkg::*;

    // current position
    coord_t x;
    coord_t y;

    // previous position, velocity is implied by x - px
    coord_t px;
    coord_t py;

    always_ff @(posedge clk) begin
        if (reset) begin
            // hanging straight down from BASE_X, at rest
            x  <= BASE_X;
            y  <= coord_t'(node_id) * NODE_SPACING;
            px <= BASE_X;
            py <= coord_t'(node_id) * NODE_SPACING;
        end else if (verlet_state) begin
            // x' = 2x - px, inertia only
            x  <= (x <<< 1) - px;
            // y' = 2y - py + g, gravity pulls toward larger y
            y  <= (y <<< 1) - py + GRAVITY;
            // old current becomes the new previous
            px <= x;
            py <= y;
        end else if (fix_constraint_state) begin
            // take the solver result, keep px/py
            // so the correction shows up as velocity next step
            x <= x_fix_constraint;
            y <= y_fix_constraint;
        end
    end

    assign x_pos = x;
    assign y_pos = y;

endmodule

`default_nettype wire

// File: src/rope_constraint.sv
/* Anchor pinning plus per-axis rest-length clamp, purely combinational.
   Not a true distance constraint and no relaxation, one chained pass only. */
`timescale 1ns/10ps
`default_nettype none

module rope_constraint (
    input  wire rope_sim_pkg::coord_t anchor_x,
    input  wire rope_sim_pkg::coord_t anchor_y,
    input  wire rope_sim_pkg::coord_t x_in  [rope_sim_pkg::NUM_NODES],
    input  wire rope_sim_pkg::coord_t y_in  [rope_sim_pkg::NUM_NODES],
    output rope_sim_pkg::coord_t      x_fix [rope_sim_pkg::NUM_NODES],
    output rope_sim_pkg::coord_t      y_fix [rope_sim_pkg::NUM_NODES]
);

    import rope_sim_pkg::*;

    // clamp one axis to within REST_LEN of the constrained predecessor
    // offset is taken with wrapping arithmetic, like the rest of the datapath
    function automatic coord_t clamp_axis(
        input coord_t pos,
        input coord_t pred
    );
        coord_t offset;
        coord_t result;
        offset = pos - pred;
        if (offset > REST_LEN) begin
            // too far on the positive side
            result = pred + REST_LEN;
        end else if (offset < -REST_LEN) begin
            // too far on the negative side
            result = pred - REST_LEN;
        end else begin
            // inside the band, leave as integrated
            result = pos;
        end
        return result;
    endfunction

    // node 0 ignores its integrated position and sits on the anchor
    assign x_fix[0] = anchor_x;
    assign y_fix[0] = anchor_y;

    // each later node is clamped against the already fixed node before it,
    // so a large anchor move ripples down the chain in the same cycle
    for (genvar i = 1; i < NUM_NODES; i++) begin : g_clamp
        // x and y are independent, no coupling between axes
        assign x_fix[i] = clamp_axis(x_in[i], x_fix[i-1]);
        assign y_fix[i] = clamp_axis(y_in[i], y_fix[i-1]);
    end

    // x_in[0] and y_in[0] are not needed, node 0 is fully pinned

endmodule

`default_nettype wire

// File: src/position_readout.sv
/* Registered readout of one node position, one cycle behind node_sel.
   Clears to node 0's reset position. */
`timescale 1ns/10ps
`default_nettype none

module position_readout (
    input  wire logic                    clk,
    input  wire logic                    reset,
    input  wire rope_sim_pkg::node_sel_t node_sel,
    input  wire rope_sim_pkg::coord_t    x_in [rope_sim_pkg::NUM_NODES],
    input  wire rope_sim_pkg::coord_t    y_in [rope_sim_pkg::NUM_NODES],
    output rope_sim_pkg::coord_t         sel_x,
    output rope_sim_pkg::coord_t         sel_y
);

    import rope_sim_pkg::*;

    always_ff @(posedge clk) begin
        if (reset) begin
            // node 0 reset position, index 0 so y is zero
            sel_x <= BASE_X;
            sel_y <= '0;
        end else begin
            // follows the nodes every cycle, not only after a step
            sel_x <= x_in[node_sel];
            sel_y <= y_in[node_sel];
        end
    end

endmodule

`default_nettype wire

// File: src/rope_sim_top.sv
/* 2D rope of NUM_NODES Q16.16 masses hanging from a movable anchor.
   One step takes 3 cycles. Anchor is sampled in the constraint cycle. */
`timescale 1ns/10ps
`default_nettype none

module rope_sim_top (
    input  wire logic                    clk,
    input  wire logic                    reset,
    input  wire logic                    step,
    input  wire rope_sim_pkg::coord_t    anchor_x,
    input  wire rope_sim_pkg::coord_t    anchor_y,
    input  wire rope_sim_pkg::node_sel_t node_sel,
    output logic                         step_done,
    output logic                         busy,
    output rope_sim_pkg::coord_t         sel_x,
    output rope_sim_pkg::coord_t         sel_y
);

    import rope_sim_pkg::*;

    // phase strobes to every node
    logic verlet_state;
    logic fix_constraint_state;

    // node positions after integration or constraint
    coord_t x_pos [NUM_NODES];
    coord_t y_pos [NUM_NODES];

    // solver output, loaded by the nodes in the constraint cycle
    coord_t x_fix [NUM_NODES];
    coord_t y_fix [NUM_NODES];

    // input side, step pulse to phase strobes
    step_sequencer step_sequencer_inst (
        .clk                  (clk),
        .reset                (reset),
        .step                 (step),
        .verlet_state         (verlet_state),
        .fix_constraint_state (fix_constraint_state),
        .step_done            (step_done),
        .busy                 (busy)
    );

    // one mass per index, each with its own reset height
    for (genvar i = 0; i < NUM_NODES; i++) begin : g_node
        verlet_node #(
            .node_id (i)
        ) verlet_node_inst (
            .clk                  (clk),
            .reset                (reset),
            .verlet_state         (verlet_state),
            .fix_constraint_state (fix_constraint_state),
            .x_fix_constraint     (x_fix[i]),
            .y_fix_constraint     (y_fix[i]),
            .x_pos                (x_pos[i]),
            .y_pos                (y_pos[i])
        );
    end

    // settles combinationally from the positions integrated in cycle 1
    rope_constraint rope_constraint_inst (
        .anchor_x (anchor_x),
        .anchor_y (anchor_y),
        .x_in     (x_pos),
        .y_in     (y_pos),
        .x_fix    (x_fix),
        .y_fix    (y_fix)
    );

    // output side
    position_readout position_readout_inst (
        .clk      (clk),
        .reset    (reset),
        .node_sel (node_sel),
        .x_in     (x_pos),
        .y_in     (y_pos),
        .sel_x    (sel_x),
        .sel_y    (sel_y)
    );

endmodule

`default_nettype wire

// File: dv/tb_clock_gen.sv
/* Testbench clock with a 40 ns period, reset high for the first 8 cycles.
   Reset is released on a falling edge like every other DUT input. */
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic reset
);

    // 20 ns half period
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (8) @(posedge clk);
        // drop reset away from the sampling edge
        @(negedge clk);
        reset = 1'b0;
    end

endmodule

`default_nettype wire

// File: dv/rope_sim_properties.sv
/* Concurrent checks on the step sequencer strobes, bound into step_sequencer.
   Strobe rules are disabled while reset is high. */
`timescale 1ns/10ps
`default_nettype none

module rope_sim_properties (
    input wire logic clk,
    input wire logic reset,
    input wire logic verlet_state,
    input wire logic fix_constraint_state,
    input wire logic step_done,
    input wire logic busy
);

    // integration and constraint never share a cycle
    assert property (@(posedge clk) disable iff (reset)
        !(verlet_state && fix_constraint_state))
        else $error("verlet_state and fix_constraint_state high together");

    // constraint cycle directly after the integration cycle
    assert property (@(posedge clk) disable iff (reset)
        verlet_state |=> fix_constraint_state)
        else $error("fix_constraint_state did not follow verlet_state");

    // done one cycle after the constraint load
    assert property (@(posedge clk) disable iff (reset)
        fix_constraint_state |=> step_done)
        else $error("step_done did not follow fix_constraint_state");

    // a clocked reset leaves the sequencer idle
    assert property (@(posedge clk)
        reset |=> !busy)
        else $error("busy high during reset");

endmodule

`default_nettype wire

// File: dv/tb_rope_sim.sv
/* Table-driven testbench for rope_sim_top with a rope model in Q16.16.
   Expected positions come from the model, random anchors use an LCG with seed 19. */
`timescale 1ns/10ps
`default_nettype none

module tb_rope_sim;

    import rope_sim_pkg::*;

    // bound on every wait for step_done, in cycles
    localparam int STEP_TIMEOUT  = 10;
    localparam int RESET_TIMEOUT = 20;

    // one table row: anchor, step count, extra pulse while busy, node to read
    typedef struct packed {
        coord_t    ax;
        coord_t    ay;
        int        steps;
        logic      dup;
        node_sel_t node;
    } row_t;

    logic      clk;
    logic      reset;
    logic      step;
    coord_t    anchor_x;
    coord_t    anchor_y;
    node_sel_t node_sel;
    logic      step_done;
    logic      busy;
    coord_t    sel_x;
    coord_t    sel_y;

    // rope model, current and previous position per node
    coord_t mx  [NUM_NODES];
    coord_t my  [NUM_NODES];
    coord_t mpx [NUM_NODES];
    coord_t mpy [NUM_NODES];

    // node the readout register holds right now
    node_sel_t shown_sel;

    row_t        rows[$];
    int unsigned lcg_state = 32'd19;
    int          value_errors = 0;
    int          timing_errors = 0;
    int          timeouts = 0;

    tb_clock_gen tb_clock_gen_inst (
        .clk   (clk),
        .reset (reset)
    );

    rope_sim_top rope_sim_top_inst (
        .clk       (clk),
        .reset     (reset),
        .step      (step),
        .anchor_x  (anchor_x),
        .anchor_y  (anchor_y),
        .node_sel  (node_sel),
        .step_done (step_done),
        .busy      (busy),
        .sel_x     (sel_x),
        .sel_y     (sel_y)
    );

    bind step_sequencer rope_sim_properties rope_sim_properties_inst (.*);

    // whole units to Q16.16
    function automatic coord_t to_q(input int whole);
        return coord_t'(whole * 65536);
    endfunction

    // classic 32-bit LCG, wraps mod 2^32
    function automatic int unsigned next_random();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // offset of up to about +-16.0 from bits 26:16 of a random word
    function automatic coord_t small_offset(input int unsigned r);
        return coord_t'((int'((r >> 16) & 32'h7ff) - 1024) * 1024);
    endfunction

    // keep one axis within REST_LEN of the fixed neighbour above it
    function automatic coord_t pull_within_rest(input coord_t pos, input coord_t prev);
        coord_t d;
        d = pos - prev;
        if (d > REST_LEN)
            return prev + REST_LEN;
        if (d < -REST_LEN)
            return prev - REST_LEN;
        return pos;
    endfunction

    task automatic model_reset();
        for (int i = 0; i < NUM_NODES; i++) begin
            mx[i]  = BASE_X;
            my[i]  = coord_t'(i) * NODE_SPACING;
            mpx[i] = mx[i];
            mpy[i] = my[i];
        end
    endtask

    // integrate every node, then pin node 0 and clamp down the chain
    task automatic model_step(input coord_t ax, input coord_t ay);
        coord_t nx;
        coord_t ny;
        for (int i = 0; i < NUM_NODES; i++) begin
            nx     = 2 * mx[i] - mpx[i];
            ny     = 2 * my[i] - mpy[i] + GRAVITY;
            mpx[i] = mx[i];
            mpy[i] = my[i];
            mx[i]  = nx;
            my[i]  = ny;
        end
        mx[0] = ax;
        my[0] = ay;
        for (int i = 1; i < NUM_NODES; i++) begin
            mx[i] = pull_within_rest(mx[i], mx[i-1]);
            my[i] = pull_within_rest(my[i], my[i-1]);
        end
    endtask

    task automatic add_row(input coord_t ax, input coord_t ay, input int steps,
                           input logic dup, input node_sel_t node);
        row_t r;
        r.ax    = ax;
        r.ay    = ay;
        r.steps = steps;
        r.dup   = dup;
        r.node  = node;
        rows.push_back(r);
    endtask

    // entered on a falling edge, readout is one cycle behind node_sel
    task automatic check_node(input node_sel_t idx);
        node_sel = idx;
        // register keeps the old selection until the next rising edge
        #1;
        assert (sel_x == mx[shown_sel]) else begin
            value_errors++;
            $display("Fail sel_x before edge node %0d: expected %h, got %h",
                     shown_sel, mx[shown_sel], sel_x);
        end
        assert (sel_y == my[shown_sel]) else begin
            value_errors++;
            $display("Fail sel_y before edge node %0d: expected %h, got %h",
                     shown_sel, my[shown_sel], sel_y);
        end
        @(negedge clk);
        assert (sel_x == mx[idx]) else begin
            value_errors++;
            $display("Fail sel_x node %0d: expected %h, got %h", idx, mx[idx], sel_x);
        end
        assert (sel_y == my[idx]) else begin
            value_errors++;
            $display("Fail sel_y node %0d: expected %h, got %h", idx, my[idx], sel_y);
        end
        shown_sel = idx;
    endtask

    task automatic check_all_nodes();
        for (int i = 0; i < NUM_NODES; i++)
            check_node(node_sel_t'(i));
    endtask

    // one accepted step, optional second pulse in the first busy cycle
    task automatic run_step(input coord_t ax, input coord_t ay, input logic dup);
        int cycles;
        int extra_done;
        logic done_seen;
        cycles     = 0;
        extra_done = 0;
        done_seen  = 1'b0;
        anchor_x   = ax;
        anchor_y   = ay;
        step       = 1'b1;
        while (!done_seen && cycles < STEP_TIMEOUT) begin
            @(negedge clk);
            cycles++;
            // second pulse lands while busy and must be dropped
            step = dup && (cycles == 1);
            assert (busy == 1'b1) else begin
                timing_errors++;
                $display("Fail busy cycle %0d: expected %h, got %h", cycles, 1'b1, busy);
            end
            done_seen = step_done;
        end
        step = 1'b0;
        if (!done_seen) begin
            timeouts++;
            $display("Timed out waiting for step_done after %0d cycles", cycles);
        end else begin
            assert (cycles == 3) else begin
                timing_errors++;
                $display("Fail step_done latency: expected %h, got %h", 3, cycles);
            end
            model_step(ax, ay);
        end
        // sequencer back to idle, no second done from a dropped pulse
        repeat (3) begin
            @(negedge clk);
            if (step_done)
                extra_done++;
        end
        assert (busy == 1'b0) else begin
            timing_errors++;
            $display("Fail busy after step: expected %h, got %h", 1'b0, busy);
        end
        assert (extra_done == 0) else begin
            timing_errors++;
            $display("Fail step_done extra pulses: expected %h, got %h", 0, extra_done);
        end
    endtask

    initial begin : main_seq
        int          wait_cycles;
        int unsigned rx;
        int unsigned ry;
        int unsigned rs;
        row_t        r;
        step      = 1'b0;
        anchor_x  = BASE_X;
        anchor_y  = '0;
        node_sel  = '0;
        shown_sel = '0;
        model_reset();

        // directed rows: hang at rest, sideways jumps, a lowered anchor
        add_row(BASE_X, '0, 6, 1'b0, node_sel_t'(3));
        add_row(BASE_X + to_q(25), '0, 3, 1'b1, node_sel_t'(1));
        add_row(BASE_X - to_q(30), to_q(5), 4, 1'b0, node_sel_t'(2));
        add_row(BASE_X, to_q(40), 5, 1'b1, node_sel_t'(3));
        add_row(BASE_X, to_q(-25), 2, 1'b0, node_sel_t'(1));
        // random rows near the reset anchor
        for (int k = 0; k < 6; k++) begin
            rx = next_random();
            ry = next_random();
            rs = next_random();
            add_row(BASE_X + small_offset(rx), small_offset(ry), 1 + int'((rs >> 16) % 3),
                    rs[20], node_sel_t'(rs >> 24));
        end

        // reset is still X at time zero, look at it on falling edges only
        wait_cycles = 0;
        do begin
            @(negedge clk);
            wait_cycles++;
        end while (reset !== 1'b0 && wait_cycles < RESET_TIMEOUT);
        if (reset !== 1'b0) begin
            timeouts++;
            $display("Timed out waiting for reset to be released");
        end

        // every node at its reset position
        check_all_nodes();

        foreach (rows[n]) begin
            r = rows[n];
            for (int s = 0; s < r.steps; s++) begin
                run_step(r.ax, r.ay, r.dup);
                check_node(r.node);
            end
            // full sweep covers every readout index
            check_all_nodes();
        end

        $display("Summary: %0d value errors, %0d timing errors, %0d timeouts",
                 value_errors, timing_errors, timeouts);
        if (value_errors == 0 && timing_errors == 0 && timeouts == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
src/rope_sim_pkg.sv
src/step_sequencer.sv
src/verlet_node.sv
src/rope_constraint.sv
src/position_readout.sv
src/rope_sim_top.sv
dv/tb_clock_gen.sv
dv/rope_sim_properties.sv
dv/tb_rope_sim.sv

// File: Bender.yml
package:
  name: rope_sim

sources:
  # package first, then the RTL bottom up
  - src/rope_sim_pkg.sv
  - src/step_sequencer.sv
  - src/verlet_node.sv
  - src/rope_constraint.sv
  - src/position_readout.sv
  - src/rope_sim_top.sv
  # simulation only
  - target: test
    files:
      - dv/tb_clock_gen.sv
      - dv/rope_sim_properties.sv
      - dv/tb_rope_sim.sv
